//--- design/zx_addr_map.sv
// Slot to RAM address mapper
`timescale 1ns/1ns

module zx_addr_map
	import zx_mem_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  mapped_t  mapped,
	output ram_req_t ram_req
);

	logic                  special;
	logic [3:0]            rom_page;
	logic [2:0]            special_bank;
	logic [5:0]            bank_num;
	logic                  rom_slot;
	logic [RAM_ADDR_W-1:0] base_addr;
	logic [RAM_ADDR_W-1:0] addr_next;

	logic                  valid_q;
	logic                  we_q;
	logic [RAM_ADDR_W-1:0] addr_q;

	// All-RAM modes exist on +3 only
	assign special = mapped.page.is_plus3 && mapped.page.reg_1ffd[0];
	assign rom_slot = !special && mapped.slot == 2'd0;

	// ==================================================================
	// ROM page and bank choice
	// ==================================================================

	always_comb begin
		if (mapped.page.is_48)
			rom_page = 4'd15;
		else if (mapped.page.is_plus3)
			rom_page = {2'b10, mapped.page.reg_1ffd[2], mapped.page.reg_7ffd[4]};
		else
			rom_page = {3'b011, mapped.page.reg_7ffd[4]};
	end

	// Special bank sets 0123, 4567, 4563, 4763
	always_comb begin
		case (mapped.page.reg_1ffd[2:1])
			2'd0: special_bank = {1'b0, mapped.slot};
			2'd1: special_bank = {1'b1, mapped.slot};
			2'd2: special_bank = (mapped.slot == 2'd3) ? 3'd3 : {1'b1, mapped.slot};
			default: begin
				case (mapped.slot)
					2'd0: special_bank = 3'd4;
					2'd1: special_bank = 3'd7;
					2'd2: special_bank = 3'd6;
					default: special_bank = 3'd3;
				endcase
			end
		endcase
	end

	always_comb begin
		if (special) begin
			bank_num = {3'd0, special_bank};
		end else begin
			case (mapped.slot)
				2'd1: bank_num = 6'd5;
				2'd2: bank_num = 6'd2;
				default: bank_num = {mapped.bank_hi, mapped.page.reg_7ffd[2:0]};
			endcase
		end
	end

	// ==================================================================
	// Address and output register
	// ==================================================================

	always_comb begin
		if (rom_slot)
			base_addr = ROM_BASE + RAM_ADDR_W'(rom_page) * BANK_SIZE;
		else
			base_addr = RAM_ADDR_W'(bank_num) * BANK_SIZE;
		addr_next = base_addr + RAM_ADDR_W'(mapped.offset);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			// ROM is read only
			valid_q <= mapped.valid && !(rom_slot && mapped.is_write);
		end

		we_q   <= mapped.is_write;
		addr_q <= addr_next;
	end

	assign ram_req = '{valid: valid_q, we: we_q, addr: addr_q, reserved: 7'd0};

	// Nothing above ROM page 15 is ever reached
	assert property (@(posedge clk_sys) disable iff (reset)
		ram_req.valid |-> ram_req.addr[24:21] == 4'd0)
		else $error("ram_req.addr %07h out of range", ram_req.addr);

endmodule

//--- design/zx_bus_decode.sv
// Z80 bus access decoder
`timescale 1ns/1ns

module zx_bus_decode
	import zx_mem_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  bus_req_t bus_in,
	input  mach_t    mach,
	output decoded_t dec
);

	logic [15:0] io_addr;
	logic        kind_ok;
	logic        is_io;
	port_t       port_sel;

	assign io_addr = bus_in.addr;
	assign kind_ok = bus_in.kind inside {ACC_MEM_RD, ACC_MEM_WR, ACC_IO_WR};
	assign is_io   = bus_in.kind == ACC_IO_WR;

	// ==================================================================
	// Port match, qualified by the model
	// ==================================================================

	always_comb begin
		port_sel = PORT_NONE;
		if (is_io) begin
			// 1FFD and 7FFD are told apart by A14 on +3
			if (mach == MACH_PLUS3 && io_addr[15:12] == 4'b0001 && !io_addr[1])
				port_sel = PORT_1FFD;
			else if (!io_addr[15] && !io_addr[1] && (io_addr[14] || mach != MACH_PLUS3))
				port_sel = PORT_7FFD;
			else if (mach == MACH_PROFI && io_addr == PORT_DFFD_ADDR)
				port_sel = PORT_DFFD;
			else if (mach == MACH_P1024 && io_addr[15:12] == 4'b1110 && !io_addr[3])
				port_sel = PORT_EFF7;
		end
	end

	// ==================================================================
	// Output register
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid <= bus_in.valid && kind_ok;
		end

		dec.is_write <= bus_in.kind != ACC_MEM_RD;
		dec.is_io    <= is_io;
		dec.port     <= port_sel;
		// Slot from the top two address bits
		dec.slot     <= io_addr[15:14];
		dec.offset   <= io_addr[BANK_OFFSET_W-1:0];
		dec.data     <= bus_in.data;
	end

	// Bus master never issues the spare kind
	assert property (@(posedge clk_sys) disable iff (reset)
		bus_in.valid |-> kind_ok)
		else $error("bus_in.kind %0h is not a valid access", bus_in.kind);

endmodule

//--- design/zx_mem_pager.sv
// Memory paging unit top
`timescale 1ns/1ns

module zx_mem_pager
	import zx_mem_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  mach_t    mach_sel,
	input  bus_req_t bus_in,
	output ram_req_t ram_req
);

	decoded_t dec;
	mapped_t  mapped;
	// Latched model fed back to the decoder
	mach_t    mach;

	// ==================================================================
	// Three stage pipeline
	// ==================================================================

	zx_bus_decode u_bus_decode (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus_in  (bus_in),
		.mach    (mach),
		.dec     (dec)
	);

	zx_paging_regs u_paging_regs (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mach_sel (mach_sel),
		.dec      (dec),
		.mach     (mach),
		.mapped   (mapped)
	);

	zx_addr_map u_addr_map (
		.clk_sys (clk_sys),
		.reset   (reset),
		.mapped  (mapped),
		.ram_req (ram_req)
	);

endmodule

//--- design/zx_mem_pkg.sv
// ZX Spectrum paging unit types
package zx_mem_pkg;

	// ==================================================================
	// Memory map constants
	// ==================================================================

	localparam int RAM_ADDR_W    = 25;
	localparam int BANK_OFFSET_W = 14;

	// ROM page 0 sits above the 64 banks of paged RAM
	localparam logic [RAM_ADDR_W-1:0] ROM_BASE  = 25'h140000;
	localparam logic [RAM_ADDR_W-1:0] BANK_SIZE = 25'h004000;

	// Profi extra bank port, fully decoded
	localparam logic [15:0] PORT_DFFD_ADDR = 16'hDFFD;

	// ==================================================================
	// Enumerations
	// ==================================================================

	// Machine model, same order as the model menu
	typedef enum logic [2:0] {
		MACH_128   = 3'd0,
		MACH_P1024 = 3'd1,
		MACH_PROFI = 3'd2,
		MACH_48    = 3'd3,
		MACH_PLUS3 = 3'd4
	} mach_t;

	localparam mach_t MACH_LAST = MACH_PLUS3;

	// Z80 bus access kind; encoding 3 is unused
	typedef enum logic [1:0] {
		ACC_MEM_RD = 2'd0,
		ACC_MEM_WR = 2'd1,
		ACC_IO_WR  = 2'd2
	} acc_kind_t;

	typedef enum logic [2:0] {
		PORT_NONE = 3'd0,
		PORT_7FFD = 3'd1,
		PORT_1FFD = 3'd2,
		PORT_DFFD = 3'd3,
		PORT_EFF7 = 3'd4
	} port_t;

	// ==================================================================
	// Stage payloads
	// ==================================================================

	typedef struct packed {
		logic        valid;
		acc_kind_t   kind;
		logic [15:0] addr;
		logic [7:0]  data;
	} bus_req_t;

	// Slot and offset for memory, port and data for I/O
	typedef struct packed {
		logic                     valid;
		logic                     is_write;
		logic                     is_io;
		port_t                    port;
		logic [1:0]               slot;
		logic [BANK_OFFSET_W-1:0] offset;
		logic [7:0]               data;
	} decoded_t;

	// is_plus3 selects the +3 ROM layout and special modes
	typedef struct packed {
		logic [7:0] reg_7ffd;
		logic [7:0] reg_1ffd;
		logic       is_48;
		logic       is_plus3;
	} page_state_t;

	typedef struct packed {
		logic                     valid;
		logic                     is_write;
		logic [1:0]               slot;
		logic [BANK_OFFSET_W-1:0] offset;
		page_state_t              page;
		logic [2:0]               bank_hi;
	} mapped_t;

	typedef struct packed {
		logic                  valid;
		logic                  we;
		logic [RAM_ADDR_W-1:0] addr;
		logic [6:0]            reserved;
	} ram_req_t;

endpackage

//--- design/zx_paging_regs.sv
// Paging register file
`timescale 1ns/1ns

module zx_paging_regs
	import zx_mem_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  mach_t    mach_sel,
	input  decoded_t dec,
	output mach_t    mach,
	output mapped_t  mapped
);

	mach_t       mach_q;
	logic [7:0]  reg_7ffd;
	logic [7:0]  reg_1ffd;
	logic [2:0]  bank_hi;
	// Bit 2 of EFF7, freezes the Pentagon high bank bits
	logic        eff7_b2;
	logic        lock;
	logic        io_wr;
	page_state_t page_now;

	assign mach  = mach_q;
	assign io_wr = dec.valid && dec.is_io;

	// 48K never pages, Pentagon 1024 needs EFF7 bit 2 for the lock
	assign lock = (mach_q == MACH_48)
		|| (mach_q != MACH_P1024 && reg_7ffd[5])
		|| (mach_q == MACH_P1024 && reg_7ffd[5] && eff7_b2);

	assign page_now = '{
		reg_7ffd: reg_7ffd,
		reg_1ffd: reg_1ffd,
		is_48:    mach_q == MACH_48,
		is_plus3: mach_q == MACH_PLUS3
	};

	// ==================================================================
	// Model latch and paging registers
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mach_q   <= mach_sel;
			reg_7ffd <= 8'd0;
			reg_1ffd <= 8'd0;
			bank_hi  <= 3'd0;
			eff7_b2  <= 1'b0;
		end else if (io_wr) begin
			case (dec.port)
				PORT_7FFD: begin
					if (!lock) begin
						reg_7ffd <= dec.data;
						// Pentagon 1024 takes bits 7:5 as high bank bits
						if (mach_q == MACH_P1024 && !eff7_b2)
							bank_hi <= {dec.data[5], dec.data[7:6]};
					end
				end
				PORT_1FFD: begin
					if (!lock)
						reg_1ffd <= dec.data;
				end
				PORT_DFFD: bank_hi <= dec.data[2:0];
				PORT_EFF7: eff7_b2 <= dec.data[2];
				default: ;
			endcase
		end
	end

	// ==================================================================
	// Tag memory accesses with the page state
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mapped.valid <= 1'b0;
		end else begin
			mapped.valid <= dec.valid && !dec.is_io;
		end

		mapped.is_write <= dec.is_write;
		mapped.slot     <= dec.slot;
		mapped.offset   <= dec.offset;
		mapped.page     <= page_now;
		mapped.bank_hi  <= bank_hi;
	end

	assert property (@(posedge clk_sys) disable iff (reset)
		mach_q <= MACH_LAST)
		else $error("latched model %0d out of range", mach_q);

	// Registers hold their cleared value for the whole reset
	assert property (@(posedge clk_sys)
		reset && $past(reset) |=> $stable({reg_7ffd, reg_1ffd, bank_hi, eff7_b2}))
		else $error("paging register changed during reset");

endmodule

//--- list.f
+incdir+sim
design/zx_mem_pkg.sv
design/zx_bus_decode.sv
design/zx_paging_regs.sv
design/zx_addr_map.sv
design/zx_mem_pager.sv
sim/tb_zx_mem_pager.sv

//--- sim/zx_mem_checks.svh
// Request scoreboard checks

	// Compare one request with the oldest expected entry
	task automatic check_req(input ram_req_t got);
		exp_item_t head;
		// Entries whose due cycle has passed never showed up
		while (exp_q.size() > 0 && exp_q[0].due < cycle_cnt) begin
			head = exp_q.pop_front();
			$display("Missing request for address %07h, due at cycle %0d",
				head.req.addr, head.due);
			missing_errs++;
		end
		if (exp_q.size() == 0 || exp_q[0].due != cycle_cnt) begin
			$display("Unexpected request for address %07h at cycle %0d", got.addr, cycle_cnt);
			extra_errs++;
		end else begin
			head = exp_q.pop_front();
			if (got.we !== head.req.we) begin
				$display("[ERROR] ram_req.we got %h expected %h", got.we, head.req.we);
				value_errs++;
			end
			if (got.addr !== head.req.addr) begin
				$display("[ERROR] ram_req.addr got %07h expected %07h", got.addr, head.req.addr);
				value_errs++;
			end
			if (got.reserved !== 7'h00) begin
				$display("[ERROR] ram_req.reserved got %02h expected %02h", got.reserved, 7'h00);
				value_errs++;
			end
		end
	endtask

	// Idle pipe, nothing left to match
	task automatic check_quiet(input ram_req_t got);
		exp_item_t head;
		if (got.valid !== 1'b0) begin
			$display("[ERROR] ram_req.valid got %h expected %h", got.valid, 1'b0);
			value_errs++;
		end
		while (exp_q.size() > 0) begin
			head = exp_q.pop_front();
			$display("Request for address %07h never arrived", head.req.addr);
			missing_errs++;
		end
	endtask

//--- sim/tb_zx_mem_pager.sv
// Memory paging unit testbench
`timescale 1ns/1ns

module tb_zx_mem_pager
	import zx_mem_pkg::*;
();

	typedef struct packed {
		logic       is_model;
		logic [2:0] mach;
		bus_req_t   bus;
		logic       has_req;
		ram_req_t   exp;
	} step_t;

	typedef struct packed {
		ram_req_t req;
		int       due;
	} exp_item_t;

	logic      clk_sys;
	logic      reset;
	mach_t     mach_sel;
	bus_req_t  bus_in;
	ram_req_t  ram_req;

	step_t     steps[$];
	exp_item_t exp_q[$];
	int        cycle_cnt;
	int        value_errs;
	int        missing_errs;
	int        extra_errs;
	int        other_errs;
	int        sections;
	int        limit_ns;

	zx_mem_pager u_dut (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mach_sel (mach_sel),
		.bus_in   (bus_in),
		.ram_req  (ram_req)
	);

	`include "zx_mem_checks.svh"

	always #20 clk_sys = ~clk_sys;

	// Outputs read at the rising edge, before the DUT registers update
	always @(posedge clk_sys) begin
		cycle_cnt = cycle_cnt + 1;
		if (ram_req.valid)
			check_req(ram_req);
	end

	// ==================================================================
	// Test file reader
	// ==================================================================

	task automatic load_tests();
		int               fd;
		int               n;
		logic [7:0]       c;
		logic [31:0]      kind_f;
		logic [31:0]      addr_f;
		logic [31:0]      data_f;
		logic [31:0]      req_f;
		logic [31:0]      we_f;
		logic [31:0]      raddr_f;
		logic [8*160-1:0] rest;
		step_t            st;
		fd = $fopen("sim/zx_mem_tests.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the test file sim/zx_mem_tests.txt");
			other_errs++;
			return;
		end
		n = $fscanf(fd, " %c", c);
		while (n == 1) begin
			st = '0;
			if (c == "#") begin
				n = $fgets(rest, fd);
			end else if (c == "M" && $fscanf(fd, "%h", kind_f) == 1) begin
				st.is_model = 1'b1;
				st.mach     = kind_f[2:0];
				steps.push_back(st);
				sections++;
			end else if (c == "A" && $fscanf(fd, "%h %h %h %h %h %h",
					kind_f, addr_f, data_f, req_f, we_f, raddr_f) == 6) begin
				st.bus     = '{valid: 1'b1, kind: acc_kind_t'(kind_f[1:0]),
					addr: addr_f[15:0], data: data_f[7:0]};
				st.has_req = req_f[0];
				st.exp     = '{valid: 1'b1, we: we_f[0], addr: raddr_f[24:0], reserved: 7'd0};
				steps.push_back(st);
			end else begin
				$display("Unreadable line in the test file after %0d steps", steps.size());
				other_errs++;
			end
			n = $fscanf(fd, " %c", c);
		end
		$fclose(fd);
	endtask

	task automatic drain_pipe();
		bus_in = '0;
		repeat (3) @(negedge clk_sys);
		check_quiet(ram_req);
	endtask

	// ==================================================================
	// Stimulus
	// ==================================================================

	initial begin
		step_t     st;
		exp_item_t item;
		clk_sys  = 1'b0;
		reset    = 1'b1;
		mach_sel = MACH_128;
		bus_in   = '0;
		load_tests();
		if (steps.size() == 0) begin
			$display("The test file holds no steps");
			other_errs++;
		end
		limit_ns = (steps.size() + 10 * sections + 10) * 40 * 2;
		@(negedge clk_sys);
		for (int i = 0; i < steps.size(); i++) begin
			st = steps[i];
			if (st.is_model) begin
				drain_pipe();
				reset    = 1'b1;
				mach_sel = mach_t'(st.mach);
				repeat (4) @(negedge clk_sys);
				reset    = 1'b0;
			end else begin
				bus_in = st.bus;
				// Sampled at the next edge, request due 3 edges later
				if (st.has_req) begin
					item.req = st.exp;
					item.due = cycle_cnt + 4;
					exp_q.push_back(item);
				end
				@(negedge clk_sys);
			end
		end
		drain_pipe();
		$display("Errors: %0d wrong values, %0d missing, %0d unexpected, %0d other",
			value_errs, missing_errs, extra_errs, other_errs);
		if (value_errs + missing_errs + extra_errs + other_errs == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// Watchdog sized from the test file
	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("Timeout after %0d ns, the test sequence did not finish", limit_ns);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- sim/zx_mem_tests.txt
# M <model>: new section with reset; 0=128K 1=Pentagon1024 2=Profi 3=48K 4=+3
# A <kind 0 rd 1 wr 2 io> <addr> <data> <req> <we> <ram_addr>, all hex
M 0  # 128K default map, paging, lock
A 0 0123 00 1 0 0158123
A 0 4010 00 1 0 0014010
A 1 8020 5A 1 1 0008020
A 0 C030 00 1 0 0000030
A 1 0040 11 0 0 0000000
A 2 7FFD 17 0 0 0000000
A 0 C100 00 1 0 001C100
A 0 0200 00 1 0 015C200
A 2 7FFD 21 0 0 0000000
A 0 C000 00 1 0 0004000
A 2 7FFD 07 0 0 0000000
A 1 FFFF AA 1 1 0007FFF
M 3  # 48K, ROM 15 and no paging
A 0 0000 00 1 0 017C000
A 2 7FFD 17 0 0 0000000
A 0 C010 00 1 0 0000010
A 0 0010 00 1 0 017C010
M 4  # +3 ROM pages and special bank sets
A 0 0000 00 1 0 0160000
A 2 7FFD 10 0 0 0000000
A 2 1FFD 04 0 0 0000000
A 0 0008 00 1 0 016C008
A 2 7FFD 00 0 0 0000000
A 0 000C 00 1 0 016800C
A 2 1FFD 01 0 0 0000000
A 1 0010 33 1 1 0000010
A 2 1FFD 03 0 0 0000000
A 0 C020 00 1 0 001C020
A 2 1FFD 05 0 0 0000000
A 0 C030 00 1 0 000C030
A 2 1FFD 07 0 0 0000000
A 0 4040 00 1 0 001C040
A 1 0050 55 1 1 0010050
M 1  # Pentagon 1024 high banks and EFF7
A 2 7FFD E3 0 0 0000000
A 0 C000 00 1 0 00EC000
A 2 7FFD 41 0 0 0000000
A 0 C004 00 1 0 0024004
A 2 EFF7 04 0 0 0000000
A 2 7FFD 25 0 0 0000000
A 0 C00C 00 1 0 003400C
A 2 7FFD 07 0 0 0000000
A 0 C010 00 1 0 0034010
M 2  # Profi DFFD bank bits
A 2 DFFD 05 0 0 0000000
A 0 C000 00 1 0 00A0000
A 2 7FFD 03 0 0 0000000
A 1 C100 66 1 1 00AC100
